/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := dram_tge_tb
FILELIST  := dram_tge.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := TESTBENCH PASSED

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard logic/*.svh)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dram_tge.f */
+incdir+logic
logic/tge_pkg.sv
logic/burst_reader.sv
logic/word_fifo.sv
logic/word_gearbox.sv
logic/packet_pacer.sv
logic/dram_tge.sv
tb/tb_dram_model.sv
tb/dram_tge_tb.sv

/* logic/burst_reader.sv */
`timescale 1ns/1ps
`default_nettype none
`include "tge_config.svh"

module burst_reader (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  en,
    input  logic                  hold,
    input  logic [`TGE_CNT_W-1:0] burst_size,
    output logic                  dram_request,
    output logic [`TGE_CNT_W-1:0] dram_addr
);
    import tge_pkg::*;

    localparam logic [`TGE_CNT_W-1:0] bubble_fixed = `TGE_BUBBLE;

    reader_state_t         state;
    logic [`TGE_CNT_W-1:0] burst_len;
    logic [`TGE_CNT_W-1:0] bubble_len;
    logic [`TGE_CNT_W-1:0] burst_cnt;
    logic [`TGE_CNT_W-1:0] bubble_cnt;

    // burst_size counts groups of eight reads
    assign burst_len = burst_size << 3;

    // default bubble gives the 64 bit side time to drain the burst
    assign bubble_len = (bubble_fixed != '0) ? bubble_fixed : (burst_size << 6);

    // one read per cycle, paused by a packet gap or by en
    assign dram_request = (state == RD_BURST) && en && !hold;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= RD_IDLE;
            dram_addr  <= '0;
            burst_cnt  <= '0;
            bubble_cnt <= '0;
        end else begin
            case (state)
                RD_IDLE: begin
                    burst_cnt  <= '0;
                    bubble_cnt <= '0;
                    if (en) begin
                        state <= RD_BURST;
                    end
                end
                RD_BURST: begin
                    if (dram_request) begin
                        dram_addr <= dram_addr + 1'b1;
                        burst_cnt <= burst_cnt + 1'b1;
                        if (dram_addr == `TGE_MAX_ADDR - 1) begin
                            state <= RD_DONE;
                        end else if (burst_cnt == burst_len - 1'b1) begin
                            burst_cnt  <= '0;
                            bubble_cnt <= '0;
                            state      <= RD_BUBBLE;
                        end
                    end
                end
                RD_BUBBLE: begin
                    if (bubble_cnt == bubble_len - 1'b1) begin
                        state <= RD_BURST;
                    end else begin
                        bubble_cnt <= bubble_cnt + 1'b1;
                    end
                end
                default: begin
                    // all addresses issued, wait for the next reset
                    state <= RD_DONE;
                end
            endcase
        end
    end

    a_addr_in_range: assert property (
        @(posedge clk) disable iff (rst)
        dram_request |-> (dram_addr < `TGE_MAX_ADDR)
    );

endmodule

`default_nettype wire

/* logic/dram_tge.sv */
`timescale 1ns/1ps
`default_nettype none
`include "tge_config.svh"

module dram_tge (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   en,

    // run settings, stable while out of reset
    input  logic [`TGE_CNT_W-1:0]  burst_size,
    input  logic [`TGE_CNT_W-1:0]  pkt_size,
    input  logic [`TGE_CNT_W-1:0]  wait_pkt,

    // DRAM read side
    input  logic [`TGE_DRAM_W-1:0] dram_data,
    input  logic                   dram_valid,
    output logic                   dram_request,
    output logic [`TGE_CNT_W-1:0]  dram_addr,

    // 10G transmit side
    output logic [`TGE_WORD_W-1:0] tge_data,
    output logic                   tge_valid,
    output logic                   tge_eof,
    output logic                   finish
);

    logic                   fifo_empty;
    logic [`TGE_DRAM_W-1:0] fifo_rdata;
    logic                   fifo_pop;
    logic                   send_ok;
    logic                   hold;

    burst_reader u_reader (
        .clk          (clk),
        .rst          (rst),
        .en           (en),
        .hold         (hold),
        .burst_size   (burst_size),
        .dram_request (dram_request),
        .dram_addr    (dram_addr)
    );

    word_fifo u_fifo (
        .clk    (clk),
        .rst    (rst),
        .wdata  (dram_data),
        .wvalid (dram_valid),
        .pop    (fifo_pop),
        .rdata  (fifo_rdata),
        .empty  (fifo_empty)
    );

    word_gearbox u_gearbox (
        .clk        (clk),
        .rst        (rst),
        .fifo_empty (fifo_empty),
        .fifo_rdata (fifo_rdata),
        .send_ok    (send_ok),
        .fifo_pop   (fifo_pop),
        .tge_data   (tge_data),
        .tge_valid  (tge_valid)
    );

    // pacer watches the outgoing stream and throttles both ends
    packet_pacer u_pacer (
        .clk       (clk),
        .rst       (rst),
        .tge_valid (tge_valid),
        .pkt_size  (pkt_size),
        .wait_pkt  (wait_pkt),
        .send_ok   (send_ok),
        .hold      (hold),
        .tge_eof   (tge_eof),
        .finish    (finish)
    );

endmodule

`default_nettype wire

/* logic/packet_pacer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "tge_config.svh"

module packet_pacer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  tge_valid,
    input  logic [`TGE_CNT_W-1:0] pkt_size,
    input  logic [`TGE_CNT_W-1:0] wait_pkt,
    output logic                  send_ok,
    output logic                  hold,
    output logic                  tge_eof,
    output logic                  finish
);
    import tge_pkg::*;

    // each pair of DRAM words becomes nine output words
    localparam logic [`TGE_CNT_W-1:0] total_words = `TGE_MAX_ADDR * 9 / 2;

    pacer_state_t          state;
    logic [`TGE_CNT_W-1:0] pkt_cnt;
    logic [`TGE_CNT_W-1:0] total_cnt;
    logic [`TGE_CNT_W-1:0] gap_cnt;
    logic                  pkt_end;
    logic                  last_word;

    assign pkt_end   = (pkt_cnt == pkt_size - 1'b1);
    assign last_word = (total_cnt == total_words - 1'b1);

    assign send_ok = (state == PC_SEND);
    assign hold    = (state == PC_GAP);
    assign finish  = (state == PC_DONE);

    // final word closes its packet even when short
    assign tge_eof = tge_valid && (pkt_end || last_word);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= PC_SEND;
            pkt_cnt   <= '0;
            total_cnt <= '0;
            gap_cnt   <= '0;
        end else begin
            case (state)
                PC_SEND: begin
                    if (tge_valid) begin
                        total_cnt <= total_cnt + 1'b1;
                        if (last_word) begin
                            state <= PC_DONE;
                        end else if (pkt_end) begin
                            pkt_cnt <= '0;
                            gap_cnt <= '0;
                            // zero gap keeps streaming
                            if (wait_pkt != '0) begin
                                state <= PC_GAP;
                            end
                        end else begin
                            pkt_cnt <= pkt_cnt + 1'b1;
                        end
                    end
                end
                PC_GAP: begin
                    if (gap_cnt == wait_pkt - 1'b1) begin
                        state <= PC_SEND;
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= PC_DONE;
                end
            endcase
        end
    end

    // once done, no word may leave the gearbox again
    a_finish_sticky: assert property (
        @(posedge clk) disable iff (rst)
        finish |=> finish && !tge_valid
    );

endmodule

`default_nettype wire

/* logic/tge_config.svh */
`ifndef TGE_CONFIG_SVH
`define TGE_CONFIG_SVH

// width of one DRAM word as returned by the memory
`define TGE_DRAM_W 288

// width of one word on the 10G transmit side
`define TGE_WORD_W 64

// counters and settings inputs
`define TGE_CNT_W 32

// entries in the DRAM return buffer, power of two
`define TGE_FIFO_DEPTH 16

// DRAM words read per run, must be even since words are repacked in pairs
`define TGE_MAX_ADDR 64

// fixed bubble length in cycles
// 0 selects a bubble of 64 times burst_size
`define TGE_BUBBLE 0

`endif

/* logic/tge_pkg.sv */
`default_nettype none

package tge_pkg;

    // DRAM read scheduler
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_BURST,
        RD_BUBBLE,
        RD_DONE
    } reader_state_t;

    // 288 to 64 bit repacking
    typedef enum logic [1:0] {
        GB_LOAD_LO,
        GB_LOAD_HI,
        GB_SEND
    } gearbox_state_t;

    // packet framing and gap timing
    typedef enum logic [1:0] {
        PC_SEND,
        PC_GAP,
        PC_DONE
    } pacer_state_t;

endpackage

`default_nettype wire

/* logic/word_fifo.sv */
`timescale 1ns/1ps
`default_nettype none
`include "tge_config.svh"

module word_fifo (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`TGE_DRAM_W-1:0] wdata,
    input  logic                   wvalid,
    input  logic                   pop,
    output logic [`TGE_DRAM_W-1:0] rdata,
    output logic                   empty
);

    localparam int aw = $clog2(`TGE_FIFO_DEPTH);

    logic [`TGE_DRAM_W-1:0] mem [0:`TGE_FIFO_DEPTH-1];

    // one extra bit tells full from empty
    logic [aw:0] wr_ptr;
    logic [aw:0] rd_ptr;
    logic        full;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);

    // head word is always visible, no read latency
    assign rdata = mem[rd_ptr[aw-1:0]];

    always_ff @(posedge clk) begin
        if (wvalid && !full) begin
            mem[wr_ptr[aw-1:0]] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wvalid && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // the reader bubble must keep the buffer from filling
    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        wvalid |-> !full
    );

    a_no_underflow: assert property (
        @(posedge clk) disable iff (rst)
        pop |-> !empty
    );

endmodule

`default_nettype wire

/* logic/word_gearbox.sv */
`timescale 1ns/1ps
`default_nettype none
`include "tge_config.svh"

module word_gearbox (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fifo_empty,
    input  logic [`TGE_DRAM_W-1:0] fifo_rdata,
    input  logic                   send_ok,
    output logic                   fifo_pop,
    output logic [`TGE_WORD_W-1:0] tge_data,
    output logic                   tge_valid
);
    import tge_pkg::*;

    localparam int pair_w = 2 * `TGE_DRAM_W;
    // nine output words per pair of DRAM words
    localparam logic [3:0] last_idx = 4'(pair_w / `TGE_WORD_W - 1);

    gearbox_state_t    state;
    logic [pair_w-1:0] pack;
    logic [3:0]        word_idx;

    // take the head word whenever a half is waiting to be filled
    assign fifo_pop = (state != GB_SEND) && !fifo_empty;

    // combinational so the pacer sees the word and flags eof in the same cycle
    assign tge_valid = (state == GB_SEND) && send_ok;
    assign tge_data  = pack[`TGE_WORD_W-1:0];

    // payload shift register
    always_ff @(posedge clk) begin
        if (fifo_pop && (state == GB_LOAD_LO)) begin
            pack[`TGE_DRAM_W-1:0] <= fifo_rdata;
        end else if (fifo_pop && (state == GB_LOAD_HI)) begin
            pack[pair_w-1:`TGE_DRAM_W] <= fifo_rdata;
        end else if (tge_valid) begin
            // lowest word goes out first
            pack <= pack >> `TGE_WORD_W;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= GB_LOAD_LO;
            word_idx <= '0;
        end else begin
            case (state)
                GB_LOAD_LO: begin
                    if (fifo_pop) begin
                        state <= GB_LOAD_HI;
                    end
                end
                GB_LOAD_HI: begin
                    if (fifo_pop) begin
                        word_idx <= '0;
                        state    <= GB_SEND;
                    end
                end
                GB_SEND: begin
                    if (tge_valid) begin
                        if (word_idx == last_idx) begin
                            state <= GB_LOAD_LO;
                        end else begin
                            word_idx <= word_idx + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= GB_LOAD_LO;
                end
            endcase
        end
    end

    // a popped head word must already have been written
    a_pop_data_known: assert property (
        @(posedge clk) disable iff (rst)
        fifo_pop |-> !$isunknown(fifo_rdata)
    );

endmodule

`default_nettype wire

/* tb/dram_tge_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "tge_config.svh"

module dram_tge_tb;

    localparam int latency     = 3;
    localparam int rst_cycles  = 16;
    localparam int drain       = 40;
    localparam int burst       = 1;
    localparam int total_words = `TGE_MAX_ADDR * 9 / 2;

    logic                   clk;
    logic                   rst;
    logic                   en;
    logic [`TGE_CNT_W-1:0]  burst_size;
    logic [`TGE_CNT_W-1:0]  pkt_size;
    logic [`TGE_CNT_W-1:0]  wait_pkt;
    logic [`TGE_DRAM_W-1:0] dram_data;
    logic                   dram_valid;
    logic                   dram_request;
    logic [`TGE_CNT_W-1:0]  dram_addr;
    logic [`TGE_WORD_W-1:0] tge_data;
    logic                   tge_valid;
    logic                   tge_eof;
    logic                   finish;

    logic [31:0] lcg_state;
    int          cycle_count;
    int          timeout_limit;
    int          error_count;
    int          pkt2;
    int          gap2;

    dram_tge dut0 (.*);

    tb_dram_model #(.latency(latency)) u_dram (
        .clk(clk), .rst(rst), .request(dram_request), .addr(dram_addr),
        .valid(dram_valid), .data(dram_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // DRAM word a is nine copies of a and each pair leaves low word first
    function automatic logic [`TGE_WORD_W-1:0] expected_word(input int k);
        logic [2*`TGE_DRAM_W-1:0] pair;
        logic [31:0]              lo;
        logic [31:0]              hi;
        lo = 32'(2 * (k / 9));
        hi = lo + 32'd1;
        pair = {{9{hi}}, {9{lo}}};
        return pair[(k % 9) * `TGE_WORD_W +: `TGE_WORD_W];
    endfunction

    function automatic int run_cycles(input int pkt, input int gap);
        int bubble;
        bubble = (`TGE_BUBBLE != 0) ? `TGE_BUBBLE : 64 * burst;
        return rst_cycles + `TGE_MAX_ADDR + (`TGE_MAX_ADDR / (8 * burst) + 1) * bubble
            + total_words + (total_words / pkt + 1) * gap + latency + drain;
    endfunction

    task automatic stop_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic fail_with_message(input string msg);
        error_count++;
        $display("error: %s", msg);
        stop_run();
    endtask

    task automatic check_value(input string test_name, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("** Error: %s: %s expected %h actual %h", test_name, what, expected, actual);
            stop_run();
        end
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (timeout_limit > 0 && cycle_count > timeout_limit) begin
            fail_with_message($sformatf("run did not complete within %0d cycles",
                                        timeout_limit));
        end
    end

    task automatic run_stream(input string test_name, input int pkt, input int gap);
        int   req_count;
        int   run_len;
        int   word_count;
        int   gap_left;
        int   after_finish;
        logic exp_eof;
        req_count = 0;
        run_len = 0;
        word_count = 0;
        gap_left = 0;
        after_finish = 0;
        @(posedge clk);
        rst <= 1'b1;
        en <= 1'b0;
        burst_size <= 32'(burst);
        pkt_size <= 32'(pkt);
        wait_pkt <= 32'(gap);
        repeat (rst_cycles) @(posedge clk);
        check_value(test_name, "dram_request in reset", 64'(0), 64'(dram_request));
        check_value(test_name, "tge_valid in reset", 64'(0), 64'(tge_valid));
        check_value(test_name, "tge_eof in reset", 64'(0), 64'(tge_eof));
        check_value(test_name, "finish in reset", 64'(0), 64'(finish));
        rst <= 1'b0;
        en <= 1'b1;
        while (after_finish < drain) begin
            @(posedge clk);
            check_value(test_name, "finish", 64'(word_count == total_words), 64'(finish));
            if (dram_request) begin
                check_value(test_name, "dram_addr", 64'(req_count), 64'(dram_addr));
                req_count++;
                run_len++;
                if (run_len > 8 * burst) begin
                    fail_with_message($sformatf("%s: request run longer than one burst",
                                                test_name));
                end
            end else begin
                run_len = 0;
            end
            if (tge_valid) begin
                if (word_count >= total_words || gap_left > 0) begin
                    fail_with_message($sformatf(
                        "%s: output word %0d sent after the end or inside a gap",
                        test_name, word_count));
                end
                check_value(test_name, "tge_data", 64'(expected_word(word_count)), 64'(tge_data));
                exp_eof = ((word_count + 1) % pkt == 0) || (word_count == total_words - 1);
                check_value(test_name, "tge_eof", 64'(exp_eof), 64'(tge_eof));
                if (exp_eof && word_count != total_words - 1) begin
                    gap_left = gap;
                end
                word_count++;
            end else begin
                check_value(test_name, "tge_eof without valid", 64'(0), 64'(tge_eof));
                if (gap_left > 0) begin
                    gap_left--;
                end
            end
            if (finish) begin
                check_value(test_name, "dram_request after finish", 64'(0), 64'(dram_request));
                after_finish++;
            end
        end
        check_value(test_name, "request count", 64'(`TGE_MAX_ADDR), 64'(req_count));
        check_value(test_name, "word count", 64'(total_words), 64'(word_count));
    endtask

    initial begin
        rst = 1'b1;
        en = 1'b0;
        burst_size = 32'(burst);
        pkt_size = 32'd16;
        wait_pkt = 32'd6;
        cycle_count = 0;
        error_count = 0;
        lcg_state = lcg_next(32'he881_d4e2);
        pkt2 = 4 + int'(lcg_state[20:16]);
        lcg_state = lcg_next(lcg_state);
        gap2 = 1 + int'(lcg_state[23:20]) % 12;
        timeout_limit = 2 * (run_cycles(16, 6) + run_cycles(pkt2, gap2));
        run_stream("first_run", 16, 6);
        run_stream("rerun", pkt2, gap2);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/tb_dram_model.sv */
`timescale 1ns/1ps
`default_nettype none
`include "tge_config.svh"

module tb_dram_model #(
    parameter int latency = 3
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   request,
    input  logic [`TGE_CNT_W-1:0]  addr,
    output logic                   valid,
    output logic [`TGE_DRAM_W-1:0] data
);

    // request strobes and addresses travel down a fixed delay line
    logic [latency-1:0]    valid_pipe;
    logic [`TGE_CNT_W-1:0] addr_pipe [0:latency-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[latency-2:0], request};
        end
    end

    always_ff @(posedge clk) begin
        addr_pipe[0] <= addr;
        for (int i = 1; i < latency; i++) begin
            addr_pipe[i] <= addr_pipe[i-1];
        end
    end

    assign valid = valid_pipe[latency-1];

    // returned word is the request address repeated across the whole width
    assign data = {(`TGE_DRAM_W / `TGE_CNT_W){addr_pipe[latency-1]}};

endmodule

`default_nettype wire
